// File: list.f
branch_detect_pkg.sv
branch_if.sv
operand_select.sv
branch_resolve.sv
branch_sequencer.sv
issue_slicer.sv
branch_detect_top.sv
tb_branch_detect.sv

// File: Bender.yml
package:
  name: branch_detect

sources:
  - branch_detect_pkg.sv
  - branch_if.sv
  - operand_select.sv
  - branch_resolve.sv
  - branch_sequencer.sv
  - issue_slicer.sv
  - branch_detect_top.sv
  - target: test
    files:
      - tb_branch_detect.sv

// File: tb_branch_detect.sv
`timescale 1ns/1ns

module tb_branch_detect import branch_detect_pkg::*; ();

  localparam int pkt_count    = 300;
  localparam int wait_limit   = 2000;

  logic                 w_BranchFifoFire_1;
  logic                 rstn;
  logic                 i_pkt_valid;
  inst_t [slot_num-1:0] i_pkt_inst;
  logic [data_w-1:0]    i_pkt_pc;
  logic                 o_pkt_ready;
  logic                 o_grf_req;
  logic [reg_w-1:0]     o_grf_rs1;
  logic [reg_w-1:0]     o_grf_rs2;
  logic                 i_grf_valid;
  logic [data_w-1:0]    i_grf_l;
  logic [data_w-1:0]    i_grf_r;
  logic                 o_byp_req;
  logic [dep_w-1:0]     o_byp_dep_l;
  logic [dep_w-1:0]     o_byp_dep_r;
  logic                 i_byp_valid;
  logic [data_w-1:0]    i_byp_l;
  logic [data_w-1:0]    i_byp_r;
  logic                 o_issue_valid;
  inst_t [slot_num-1:0] o_issue_inst;
  logic [slot_num-1:0]  o_issue_mask;
  logic                 o_redirect_valid;
  logic [data_w-1:0]    o_redirect_pc;
  logic                 i_issue_ready;

  logic [31:0] seed;
  int          err_count;
  int          timeout_count;
  int          slice_count;
  logic        pkt_active;

  // expected slices and operand requests of the packet in flight
  logic [slot_num-1:0]  exp_mask[$];
  inst_t [slot_num-1:0] exp_inst[$];
  logic                 exp_redir[$];
  logic [data_w-1:0]    exp_pc[$];
  logic                 exp_grf[$];
  logic                 exp_byp[$];
  logic [reg_w-1:0]     exp_rs1[$];
  logic [reg_w-1:0]     exp_rs2[$];
  logic [dep_w-1:0]     exp_dep_l[$];
  logic [dep_w-1:0]     exp_dep_r[$];

  logic                 stall_q;
  logic [slot_num-1:0]  held_mask;
  inst_t [slot_num-1:0] held_inst;
  logic                 held_redir;
  logic [data_w-1:0]    held_pc;
  logic                 cur_redir;

  logic [31:0]          rnd;
  logic                 grf_busy;
  int                   grf_wait;
  logic [reg_w-1:0]     grf_rs1_q;
  logic [reg_w-1:0]     grf_rs2_q;
  logic                 byp_busy;
  int                   byp_wait;
  logic [dep_w-1:0]     byp_dep_l_q;
  logic [dep_w-1:0]     byp_dep_r_q;

  branch_detect_top dut_i (.*);

  always #10 w_BranchFifoFire_1 = ~w_BranchFifoFire_1;

  function automatic logic [31:0] lcg_next();
    seed = seed * 32'd1664525 + 32'd1013904223;
    return seed;
  endfunction

  // small values so that compares go both ways
  function automatic logic [data_w-1:0] grf_value(input logic [reg_w-1:0] r);
    return {29'b0, r[2:0]} - 32'd4;
  endfunction

  function automatic logic [data_w-1:0] byp_value(input logic [dep_w-1:0] tag);
    return {29'b0, tag[2:0]} - 32'd3;
  endfunction

  task automatic check_value(input string what, input logic [511:0] got,
                             input logic [511:0] exp);
    if (got !== exp) begin
      err_count++;
      $display("Error at %0t ns: %s is %0h, expected %0h", $time, what, got, exp);
    end
  endtask

  task automatic push_slice(input inst_t [slot_num-1:0] pkt, input int lo, input int hi,
                            input logic redir, input logic [data_w-1:0] pc);
    logic [slot_num-1:0]  m;
    inst_t [slot_num-1:0] ins;
    for (int i = 0; i < slot_num; i++) begin
      m[i]   = (i >= lo) && (i <= hi);
      ins[i] = m[i] ? pkt[i] : inst_t'('0);
    end
    exp_mask.push_back(m);
    exp_inst.push_back(ins);
    exp_redir.push_back(redir);
    exp_pc.push_back(pc);
  endtask

  task automatic build_model(input inst_t [slot_num-1:0] pkt, input logic [data_w-1:0] pc);
    logic [slot_num-1:0] bmask;
    logic [data_w-1:0]   opl;
    logic [data_w-1:0]   opr;
    logic [data_w-1:0]   target;
    logic                taken;
    int                  sl;
    int                  sr;
    int                  lo;
    int                  s;
    lo    = 0;
    taken = 1'b0;
    for (int i = 0; i < slot_num; i++) begin
      bmask[i] = (pkt[i].opcode == op_bjp);
    end
    while (bmask != '0 && !taken) begin
      s        = first_set(bmask);
      bmask[s] = 1'b0;
      opl = (pkt[s].dep_l == dep_none) ? grf_value(pkt[s].rs1) : byp_value(pkt[s].dep_l);
      opr = (pkt[s].dep_r == dep_none) ? grf_value(pkt[s].rs2) : byp_value(pkt[s].dep_r);
      sl  = opl;
      sr  = opr;
      case (pkt[s].cond)
        cond_eq: taken = (sl == sr);
        cond_ne: taken = (sl != sr);
        cond_lt: taken = (sl < sr);
        default: taken = (sl >= sr);
      endcase
      target = pc + 32'(4 * s) + 32'(4 * int'(pkt[s].offset));
      exp_grf.push_back(pkt[s].dep_l == dep_none || pkt[s].dep_r == dep_none);
      exp_byp.push_back(pkt[s].dep_l != dep_none || pkt[s].dep_r != dep_none);
      exp_rs1.push_back(pkt[s].rs1);
      exp_rs2.push_back(pkt[s].rs2);
      exp_dep_l.push_back(pkt[s].dep_l);
      exp_dep_r.push_back(pkt[s].dep_r);
      push_slice(pkt, lo, s, taken, target);
      lo = s + 1;
    end
    if (!taken && lo < slot_num) begin
      push_slice(pkt, lo, slot_num - 1, 1'b0, '0);
    end
  endtask

  // register file, bypass and issue side, all random draws at the rising edge
  always @(posedge w_BranchFifoFire_1) begin
    i_grf_valid <= 1'b0;
    i_byp_valid <= 1'b0;
    if (rstn) begin
      rnd = lcg_next();
      i_issue_ready <= rnd[27];
      if (o_grf_req) begin
        grf_busy  = 1'b1;
        grf_wait  = rnd[31:28] % 6;
        grf_rs1_q = o_grf_rs1;
        grf_rs2_q = o_grf_rs2;
      end
      if (o_byp_req) begin
        byp_busy    = 1'b1;
        byp_wait    = rnd[23:20] % 6;
        byp_dep_l_q = o_byp_dep_l;
        byp_dep_r_q = o_byp_dep_r;
      end
      if (grf_busy) begin
        if (grf_wait == 0) begin
          i_grf_valid <= 1'b1;
          i_grf_l     <= grf_value(grf_rs1_q);
          i_grf_r     <= grf_value(grf_rs2_q);
          grf_busy = 1'b0;
        end else begin
          grf_wait--;
        end
      end
      if (byp_busy) begin
        if (byp_wait == 0) begin
          i_byp_valid <= 1'b1;
          i_byp_l     <= byp_value(byp_dep_l_q);
          i_byp_r     <= byp_value(byp_dep_r_q);
          byp_busy = 1'b0;
        end else begin
          byp_wait--;
        end
      end
    end
  end

  always @(posedge w_BranchFifoFire_1) begin
    if (rstn) begin
      if (pkt_active && o_pkt_ready) begin
        err_count++;
        $display("Error at %0t ns: o_pkt_ready high before the last slice", $time);
      end
      if (i_pkt_valid && o_pkt_ready) begin
        pkt_active = 1'b1;
      end
      if (o_grf_req || o_byp_req) begin
        if (exp_grf.size() == 0) begin
          err_count++;
          $display("Error at %0t ns: operand request with no branch left", $time);
        end else begin
          check_value("o_grf_req", o_grf_req, exp_grf.pop_front());
          check_value("o_byp_req", o_byp_req, exp_byp.pop_front());
          check_value("o_grf_rs1", o_grf_rs1, exp_rs1.pop_front());
          check_value("o_grf_rs2", o_grf_rs2, exp_rs2.pop_front());
          check_value("o_byp_dep_l", o_byp_dep_l, exp_dep_l.pop_front());
          check_value("o_byp_dep_r", o_byp_dep_r, exp_dep_r.pop_front());
        end
      end
      // a stalled slice must not change
      if (stall_q) begin
        check_value("held o_issue_valid", o_issue_valid, 1'b1);
        check_value("held o_issue_mask", o_issue_mask, held_mask);
        check_value("held o_issue_inst", o_issue_inst, held_inst);
        check_value("held o_redirect_valid", o_redirect_valid, held_redir);
        check_value("held o_redirect_pc", o_redirect_pc, held_pc);
      end
      stall_q    = o_issue_valid && !i_issue_ready;
      held_mask  = o_issue_mask;
      held_inst  = o_issue_inst;
      held_redir = o_redirect_valid;
      held_pc    = o_redirect_pc;
      if (o_issue_valid && i_issue_ready) begin
        if (exp_mask.size() == 0) begin
          err_count++;
          $display("Error at %0t ns: slice accepted with none expected", $time);
        end else begin
          slice_count++;
          cur_redir = exp_redir.pop_front();
          check_value("o_issue_mask", o_issue_mask, exp_mask.pop_front());
          check_value("o_issue_inst", o_issue_inst, exp_inst.pop_front());
          check_value("o_redirect_valid", o_redirect_valid, cur_redir);
          if (cur_redir) begin
            check_value("o_redirect_pc", o_redirect_pc, exp_pc.pop_front());
          end else begin
            void'(exp_pc.pop_front());
          end
          if (exp_mask.size() == 0) begin
            check_value("branches left unresolved", exp_grf.size(), 0);
            pkt_active = 1'b0;
          end
        end
      end
    end
  end

  initial begin
    inst_t [slot_num-1:0] pkt;
    logic [data_w-1:0]    pc;
    logic [31:0]          r1;
    logic [31:0]          r2;
    logic                 no_branch;
    int                   wait_cnt;
    seed               = 32'h877d7579;
    err_count          = 0;
    timeout_count      = 0;
    slice_count        = 0;
    pkt_active         = 1'b0;
    stall_q            = 1'b0;
    grf_busy           = 1'b0;
    byp_busy           = 1'b0;
    w_BranchFifoFire_1 = 1'b0;
    rstn               = 1'b0;
    i_pkt_valid        = 1'b0;
    i_pkt_inst         = '0;
    i_pkt_pc           = '0;
    i_grf_valid        = 1'b0;
    i_grf_l            = '0;
    i_grf_r            = '0;
    i_byp_valid        = 1'b0;
    i_byp_l            = '0;
    i_byp_r            = '0;
    i_issue_ready      = 1'b0;
    repeat (8) @(posedge w_BranchFifoFire_1);
    rstn <= 1'b1;
    @(negedge w_BranchFifoFire_1);
    check_value("o_pkt_ready after reset", o_pkt_ready, 1'b1);
    check_value("o_issue_valid after reset", o_issue_valid, 1'b0);
    check_value("o_redirect_valid after reset", o_redirect_valid, 1'b0);
    check_value("o_grf_req after reset", o_grf_req, 1'b0);
    check_value("o_byp_req after reset", o_byp_req, 1'b0);
    for (int p = 0; p < pkt_count && timeout_count == 0; p++) begin
      r1        = lcg_next();
      no_branch = (r1[31:29] == 3'd0);
      pc        = {r1[27:0], 4'b0000};
      for (int i = 0; i < slot_num; i++) begin
        r1 = lcg_next();
        r2 = lcg_next();
        case (r1[28:27])
          2'd0:    pkt[i].opcode = op_alu;
          2'd1:    pkt[i].opcode = op_load;
          2'd2:    pkt[i].opcode = op_store;
          default: pkt[i].opcode = op_nop;
        endcase
        if (!no_branch && r1[31:30] == 2'd0) begin
          pkt[i].opcode = op_bjp;
        end
        pkt[i].cond   = cond_e'(r1[26:25]);
        pkt[i].dep_l  = r1[24] ? dep_none : r1[23:20];
        pkt[i].dep_r  = r1[19] ? dep_none : r1[18:15];
        pkt[i].rs1    = r1[14:10];
        pkt[i].rs2    = r2[31:27];
        pkt[i].offset = r2[26:18];
      end
      build_model(pkt, pc);
      @(posedge w_BranchFifoFire_1);
      i_pkt_valid <= 1'b1;
      i_pkt_inst  <= pkt;
      i_pkt_pc    <= pc;
      wait_cnt = 0;
      do begin
        @(posedge w_BranchFifoFire_1);
        wait_cnt++;
      end while (!(i_pkt_valid && o_pkt_ready) && wait_cnt < wait_limit);
      i_pkt_valid <= 1'b0;
      if (wait_cnt >= wait_limit) begin
        timeout_count++;
        $display("Timed out at %0t ns waiting for the packet to be accepted", $time);
      end else begin
        wait_cnt = 0;
        do begin
          @(negedge w_BranchFifoFire_1);
          wait_cnt++;
        end while (pkt_active && wait_cnt < wait_limit);
        if (pkt_active) begin
          timeout_count++;
          $display("Timed out at %0t ns waiting for the slices of packet %0d", $time, p);
        end
      end
    end
    repeat (4) @(negedge w_BranchFifoFire_1);
    $display("Checked %0d slices: %0d errors, %0d timeouts",
             slice_count, err_count, timeout_count);
    if (err_count == 0 && timeout_count == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

// File: branch_detect_top.sv
`timescale 1ns/1ns

module branch_detect_top import branch_detect_pkg::*; (
  input  logic                 w_BranchFifoFire_1,
  input  logic                 rstn,
  input  logic                 i_pkt_valid,
  input  inst_t [slot_num-1:0] i_pkt_inst,
  input  logic [data_w-1:0]    i_pkt_pc,
  output logic                 o_pkt_ready,
  output logic                 o_grf_req,
  output logic [reg_w-1:0]     o_grf_rs1,
  output logic [reg_w-1:0]     o_grf_rs2,
  input  logic                 i_grf_valid,
  input  logic [data_w-1:0]    i_grf_l,
  input  logic [data_w-1:0]    i_grf_r,
  output logic                 o_byp_req,
  output logic [dep_w-1:0]     o_byp_dep_l,
  output logic [dep_w-1:0]     o_byp_dep_r,
  input  logic                 i_byp_valid,
  input  logic [data_w-1:0]    i_byp_l,
  input  logic [data_w-1:0]    i_byp_r,
  output logic                 o_issue_valid,
  output inst_t [slot_num-1:0] o_issue_inst,
  output logic [slot_num-1:0]  o_issue_mask,
  output logic                 o_redirect_valid,
  output logic [data_w-1:0]    o_redirect_pc,
  input  logic                 i_issue_ready
);

  logic                 slice_free;
  logic                 slice_load;
  slot_t                slice_lo;
  slot_t                slice_hi;
  logic                 slice_redirect;
  logic [data_w-1:0]    slice_target;
  inst_t [slot_num-1:0] pkt_inst;

  branch_if br_if ();

  branch_sequencer branch_sequencer_i (
    .w_BranchFifoFire_1 (w_BranchFifoFire_1),
    .rstn               (rstn),
    .i_pkt_valid        (i_pkt_valid),
    .i_pkt_inst         (i_pkt_inst),
    .i_pkt_pc           (i_pkt_pc),
    .i_slice_free       (slice_free),
    .o_pkt_ready        (o_pkt_ready),
    .o_slice_load       (slice_load),
    .o_slice_lo         (slice_lo),
    .o_slice_hi         (slice_hi),
    .o_slice_redirect   (slice_redirect),
    .o_slice_target     (slice_target),
    .o_pkt_inst         (pkt_inst),
    .br                 (br_if.seq)
  );

  branch_resolve branch_resolve_i (
    .w_BranchFifoFire_1 (w_BranchFifoFire_1),
    .rstn               (rstn),
    .br                 (br_if.res),
    .o_grf_req          (o_grf_req),
    .o_grf_rs1          (o_grf_rs1),
    .o_grf_rs2          (o_grf_rs2),
    .i_grf_valid        (i_grf_valid),
    .i_grf_l            (i_grf_l),
    .i_grf_r            (i_grf_r),
    .o_byp_req          (o_byp_req),
    .o_byp_dep_l        (o_byp_dep_l),
    .o_byp_dep_r        (o_byp_dep_r),
    .i_byp_valid        (i_byp_valid),
    .i_byp_l            (i_byp_l),
    .i_byp_r            (i_byp_r)
  );

  issue_slicer issue_slicer_i (
    .w_BranchFifoFire_1 (w_BranchFifoFire_1),
    .rstn               (rstn),
    .i_slice_load       (slice_load),
    .i_slice_lo         (slice_lo),
    .i_slice_hi         (slice_hi),
    .i_slice_redirect   (slice_redirect),
    .i_slice_target     (slice_target),
    .i_pkt_inst         (pkt_inst),
    .i_issue_ready      (i_issue_ready),
    .o_slice_free       (slice_free),
    .o_issue_valid      (o_issue_valid),
    .o_issue_inst       (o_issue_inst),
    .o_issue_mask       (o_issue_mask),
    .o_redirect_valid   (o_redirect_valid),
    .o_redirect_pc      (o_redirect_pc)
  );

endmodule

// File: issue_slicer.sv
`timescale 1ns/1ns

module issue_slicer import branch_detect_pkg::*; (
  input  logic                 w_BranchFifoFire_1,
  input  logic                 rstn,
  input  logic                 i_slice_load,
  input  slot_t                i_slice_lo,
  input  slot_t                i_slice_hi,
  input  logic                 i_slice_redirect,
  input  logic [data_w-1:0]    i_slice_target,
  input  inst_t [slot_num-1:0] i_pkt_inst,
  input  logic                 i_issue_ready,
  output logic                 o_slice_free,
  output logic                 o_issue_valid,
  output inst_t [slot_num-1:0] o_issue_inst,
  output logic [slot_num-1:0]  o_issue_mask,
  output logic                 o_redirect_valid,
  output logic [data_w-1:0]    o_redirect_pc
);

  logic [slot_num-1:0] slice_mask;

  always_comb begin
    for (int i = 0; i < slot_num; i++) begin
      slice_mask[i] = (slot_t'(i) >= i_slice_lo) && (slot_t'(i) <= i_slice_hi);
    end
  end

  always_ff @(posedge w_BranchFifoFire_1 or negedge rstn) begin
    if (!rstn) begin
      o_issue_valid    <= 1'b0;
      o_redirect_valid <= 1'b0;
    end else if (i_slice_load) begin
      o_issue_valid    <= 1'b1;
      o_redirect_valid <= i_slice_redirect;
    end else if (o_issue_valid && i_issue_ready) begin
      o_issue_valid    <= 1'b0;
      o_redirect_valid <= 1'b0;
    end
  end

  always_ff @(posedge w_BranchFifoFire_1) begin
    if (i_slice_load) begin
      o_issue_mask  <= slice_mask;
      o_redirect_pc <= i_slice_target;
      for (int i = 0; i < slot_num; i++) begin
        o_issue_inst[i] <= slice_mask[i] ? i_pkt_inst[i] : inst_t'('0);
      end
    end
  end

  // a load in flight counts as occupied
  assign o_slice_free = !o_issue_valid && !i_slice_load;

  a_mask_nonzero: assert property (@(posedge w_BranchFifoFire_1) disable iff (!rstn)
    o_issue_valid |-> (o_issue_mask != '0));

  a_hold: assert property (@(posedge w_BranchFifoFire_1) disable iff (!rstn)
    o_issue_valid && !i_issue_ready |=>
      o_issue_valid && $stable(o_issue_mask) && $stable(o_issue_inst) &&
      $stable(o_redirect_valid) && $stable(o_redirect_pc));

endmodule

// File: branch_sequencer.sv
`timescale 1ns/1ns

module branch_sequencer import branch_detect_pkg::*; (
  input  logic                        w_BranchFifoFire_1,
  input  logic                        rstn,
  input  logic                        i_pkt_valid,
  input  inst_t [slot_num-1:0]        i_pkt_inst,
  input  logic [data_w-1:0]           i_pkt_pc,
  input  logic                        i_slice_free,
  output logic                        o_pkt_ready,
  output logic                        o_slice_load,
  output slot_t                       o_slice_lo,
  output slot_t                       o_slice_hi,
  output logic                        o_slice_redirect,
  output logic [data_w-1:0]           o_slice_target,
  output inst_t [slot_num-1:0]        o_pkt_inst,
  branch_if.seq                       br
);

  typedef enum logic [2:0] {st_idle, st_scan, st_branch, st_slice, st_tail} state_e;

  state_e               state_q;
  state_e               after_load;
  inst_t [slot_num-1:0] pkt_inst_q;
  logic [data_w-1:0]    pkt_pc_q;
  logic [slot_num-1:0]  pkt_mask;
  logic [slot_num-1:0]  mask_q;
  logic [slot_num-1:0]  rem_mask;
  slot_t                cur_q;
  slot_t                next_lo_q;
  logic                 req_valid_q;
  logic                 taken;

  always_comb begin
    for (int i = 0; i < slot_num; i++) begin
      pkt_mask[i] = (i_pkt_inst[i].opcode == op_bjp);
    end
  end

  assign rem_mask = mask_q & ~(slot_num'(1) << cur_q);

  // where to go once the current slice is handed over
  always_comb begin
    taken = (state_q == st_slice) ? o_slice_redirect : br.res_taken;
    if (taken) begin
      after_load = st_idle;
    end else if (|rem_mask) begin
      after_load = st_scan;
    end else if (cur_q == slot_t'(slot_num - 1)) begin
      after_load = st_idle;
    end else begin
      after_load = st_tail;
    end
  end

  always_ff @(posedge w_BranchFifoFire_1) begin
    if (i_pkt_valid && o_pkt_ready) begin
      pkt_inst_q <= i_pkt_inst;
      pkt_pc_q   <= i_pkt_pc;
    end
  end

  always_ff @(posedge w_BranchFifoFire_1 or negedge rstn) begin
    if (!rstn) begin
      state_q          <= st_idle;
      mask_q           <= '0;
      cur_q            <= '0;
      next_lo_q        <= '0;
      req_valid_q      <= 1'b0;
      o_slice_load     <= 1'b0;
      o_slice_lo       <= '0;
      o_slice_hi       <= '0;
      o_slice_redirect <= 1'b0;
      o_slice_target   <= '0;
    end else begin
      o_slice_load <= 1'b0;
      case (state_q)
        st_idle: begin
          if (i_pkt_valid && o_pkt_ready) begin
            mask_q    <= pkt_mask;
            next_lo_q <= '0;
            state_q   <= st_scan;
          end
        end
        st_scan, st_tail: begin
          if (state_q == st_scan && |mask_q) begin
            cur_q       <= first_set(mask_q);
            req_valid_q <= 1'b1;
            state_q     <= st_branch;
          end else if (i_slice_free) begin
            // tail, or the whole packet when it has no branch
            o_slice_load     <= 1'b1;
            o_slice_lo       <= next_lo_q;
            o_slice_hi       <= slot_t'(slot_num - 1);
            o_slice_redirect <= 1'b0;
            state_q          <= st_idle;
          end else begin
            state_q <= st_tail;
          end
        end
        st_branch: begin
          if (br.res_valid) begin
            req_valid_q      <= 1'b0;
            mask_q           <= rem_mask;
            next_lo_q        <= cur_q + 1'b1;
            o_slice_lo       <= next_lo_q;
            o_slice_hi       <= cur_q;
            o_slice_redirect <= br.res_taken;
            o_slice_target   <= br.res_target;
            if (i_slice_free) begin
              o_slice_load <= 1'b1;
              state_q      <= after_load;
            end else begin
              state_q <= st_slice;
            end
          end
        end
        st_slice: begin
          if (i_slice_free) begin
            o_slice_load <= 1'b1;
            state_q      <= after_load;
          end
        end
        default: state_q <= st_idle;
      endcase
    end
  end

  assign o_pkt_ready  = (state_q == st_idle) && i_slice_free;
  assign o_pkt_inst   = pkt_inst_q;
  assign br.req_valid = req_valid_q;
  assign br.req_slot  = cur_q;
  assign br.req_inst  = pkt_inst_q[cur_q];
  assign br.req_pc    = pkt_pc_q;

  a_req_stable: assert property (@(posedge w_BranchFifoFire_1) disable iff (!rstn)
    br.req_valid && !br.res_valid |=>
      $stable(br.req_slot) && $stable(br.req_inst) && $stable(br.req_pc));

endmodule

// File: branch_resolve.sv
`timescale 1ns/1ns

module branch_resolve import branch_detect_pkg::*; (
  input  logic              w_BranchFifoFire_1,
  input  logic              rstn,
  branch_if.res             br,
  output logic              o_grf_req,
  output logic [reg_w-1:0]  o_grf_rs1,
  output logic [reg_w-1:0]  o_grf_rs2,
  input  logic              i_grf_valid,
  input  logic [data_w-1:0] i_grf_l,
  input  logic [data_w-1:0] i_grf_r,
  output logic              o_byp_req,
  output logic [dep_w-1:0]  o_byp_dep_l,
  output logic [dep_w-1:0]  o_byp_dep_r,
  input  logic              i_byp_valid,
  input  logic [data_w-1:0] i_byp_l,
  input  logic [data_w-1:0] i_byp_r
);

  logic              req_valid_d;
  logic              start;
  logic              opnd_valid;
  logic [data_w-1:0] opnd_l;
  logic [data_w-1:0] opnd_r;
  logic              taken;
  logic [data_w-1:0] target;
  logic              res_valid_q;
  logic              res_taken_q;
  logic [data_w-1:0] res_target_q;

  // rising edge of req_valid marks a new branch
  assign start = br.req_valid && !req_valid_d;

  operand_select operand_select_i (
    .w_BranchFifoFire_1 (w_BranchFifoFire_1),
    .rstn               (rstn),
    .i_start            (start),
    .i_inst             (br.req_inst),
    .i_grf_valid        (i_grf_valid),
    .i_grf_l            (i_grf_l),
    .i_grf_r            (i_grf_r),
    .i_byp_valid        (i_byp_valid),
    .i_byp_l            (i_byp_l),
    .i_byp_r            (i_byp_r),
    .o_grf_req          (o_grf_req),
    .o_grf_rs1          (o_grf_rs1),
    .o_grf_rs2          (o_grf_rs2),
    .o_byp_req          (o_byp_req),
    .o_byp_dep_l        (o_byp_dep_l),
    .o_byp_dep_r        (o_byp_dep_r),
    .o_opnd_valid       (opnd_valid),
    .o_opnd_l           (opnd_l),
    .o_opnd_r           (opnd_r)
  );

  always_comb begin
    case (br.req_inst.cond)
      cond_eq: taken = (opnd_l == opnd_r);
      cond_ne: taken = (opnd_l != opnd_r);
      cond_lt: taken = ($signed(opnd_l) < $signed(opnd_r));
      default: taken = ($signed(opnd_l) >= $signed(opnd_r));
    endcase
  end

  // word offsets, relative to the branch's own slot
  assign target = br.req_pc
                + {{(data_w - slot_w - 2){1'b0}}, br.req_slot, 2'b00}
                + {{(data_w - 11){br.req_inst.offset[8]}}, br.req_inst.offset, 2'b00};

  always_ff @(posedge w_BranchFifoFire_1 or negedge rstn) begin
    if (!rstn) begin
      req_valid_d <= 1'b0;
      res_valid_q <= 1'b0;
      res_taken_q <= 1'b0;
    end else begin
      req_valid_d <= br.req_valid;
      res_valid_q <= opnd_valid;
      if (opnd_valid) begin
        res_taken_q <= taken;
      end
    end
  end

  always_ff @(posedge w_BranchFifoFire_1) begin
    if (opnd_valid) begin
      res_target_q <= target;
    end
  end

  assign br.res_valid  = res_valid_q;
  assign br.res_taken  = res_taken_q;
  assign br.res_target = res_target_q;

endmodule

// File: operand_select.sv
`timescale 1ns/1ns

module operand_select import branch_detect_pkg::*; (
  input  logic              w_BranchFifoFire_1,
  input  logic              rstn,
  input  logic              i_start,
  input  inst_t             i_inst,
  input  logic              i_grf_valid,
  input  logic [data_w-1:0] i_grf_l,
  input  logic [data_w-1:0] i_grf_r,
  input  logic              i_byp_valid,
  input  logic [data_w-1:0] i_byp_l,
  input  logic [data_w-1:0] i_byp_r,
  output logic              o_grf_req,
  output logic [reg_w-1:0]  o_grf_rs1,
  output logic [reg_w-1:0]  o_grf_rs2,
  output logic              o_byp_req,
  output logic [dep_w-1:0]  o_byp_dep_l,
  output logic [dep_w-1:0]  o_byp_dep_r,
  output logic              o_opnd_valid,
  output logic [data_w-1:0] o_opnd_l,
  output logic [data_w-1:0] o_opnd_r
);

  logic l_from_grf;
  logic r_from_grf;
  logic sel_l_grf_q;
  logic sel_r_grf_q;
  logic grf_pend_q;
  logic byp_pend_q;
  logic busy_q;

  assign l_from_grf = (i_inst.dep_l == dep_none);
  assign r_from_grf = (i_inst.dep_r == dep_none);

  always_ff @(posedge w_BranchFifoFire_1 or negedge rstn) begin
    if (!rstn) begin
      o_grf_req  <= 1'b0;
      o_byp_req  <= 1'b0;
      grf_pend_q <= 1'b0;
      byp_pend_q <= 1'b0;
      busy_q     <= 1'b0;
    end else begin
      o_grf_req <= i_start && (l_from_grf || r_from_grf);
      o_byp_req <= i_start && !(l_from_grf && r_from_grf);
      if (i_start) begin
        grf_pend_q <= l_from_grf || r_from_grf;
        byp_pend_q <= !(l_from_grf && r_from_grf);
        busy_q     <= 1'b1;
      end else begin
        if (i_grf_valid) begin
          grf_pend_q <= 1'b0;
        end
        if (i_byp_valid) begin
          byp_pend_q <= 1'b0;
        end
        if (o_opnd_valid) begin
          busy_q <= 1'b0;
        end
      end
    end
  end

  always_ff @(posedge w_BranchFifoFire_1) begin
    if (i_start) begin
      sel_l_grf_q <= l_from_grf;
      sel_r_grf_q <= r_from_grf;
      o_grf_rs1   <= i_inst.rs1;
      o_grf_rs2   <= i_inst.rs2;
      o_byp_dep_l <= i_inst.dep_l;
      o_byp_dep_r <= i_inst.dep_r;
    end
    // each operand only listens to its own source
    if (i_grf_valid && grf_pend_q) begin
      if (sel_l_grf_q) begin
        o_opnd_l <= i_grf_l;
      end
      if (sel_r_grf_q) begin
        o_opnd_r <= i_grf_r;
      end
    end
    if (i_byp_valid && byp_pend_q) begin
      if (!sel_l_grf_q) begin
        o_opnd_l <= i_byp_l;
      end
      if (!sel_r_grf_q) begin
        o_opnd_r <= i_byp_r;
      end
    end
  end

  assign o_opnd_valid = busy_q && !grf_pend_q && !byp_pend_q;

  a_no_overlap: assert property (@(posedge w_BranchFifoFire_1) disable iff (!rstn)
    i_start |-> !busy_q && !grf_pend_q && !byp_pend_q);

endmodule

// File: branch_if.sv
`timescale 1ns/1ns

interface branch_if import branch_detect_pkg::*; ();

  logic              req_valid;
  slot_t             req_slot;
  inst_t             req_inst;
  logic [data_w-1:0] req_pc;

  logic              res_valid;
  logic              res_taken;
  logic [data_w-1:0] res_target;

  modport seq (
    output req_valid, req_slot, req_inst, req_pc,
    input  res_valid, res_taken, res_target
  );

  modport res (
    input  req_valid, req_slot, req_inst, req_pc,
    output res_valid, res_taken, res_target
  );

endinterface

// File: branch_detect_pkg.sv
package branch_detect_pkg;

  localparam int slot_num = 16;
  localparam int slot_w   = 4;
  localparam int data_w   = 32;
  localparam int dep_w    = 4;
  localparam int reg_w    = 5;

  // operand comes from the register file
  localparam logic [dep_w-1:0] dep_none = '1;

  typedef enum logic [2:0] {
    op_alu,
    op_load,
    op_store,
    op_bjp,
    op_nop
  } op_e;

  // lt and ge compare signed
  typedef enum logic [1:0] {
    cond_eq,
    cond_ne,
    cond_lt,
    cond_ge
  } cond_e;

  typedef struct packed {
    op_e               opcode;
    cond_e             cond;
    logic [dep_w-1:0]  dep_l;
    logic [dep_w-1:0]  dep_r;
    logic [reg_w-1:0]  rs1;
    logic [reg_w-1:0]  rs2;
    logic signed [8:0] offset;
  } inst_t;

  typedef logic [slot_w-1:0] slot_t;

  // lowest set slot, zero for an empty mask
  function automatic slot_t first_set(input logic [slot_num-1:0] mask);
    slot_t idx;
    idx = '0;
    for (int i = slot_num - 1; i >= 0; i--) begin
      if (mask[i]) begin
        idx = slot_t'(i);
      end
    end
    return idx;
  endfunction

endpackage
